//--- hw/ooo_defines.svh
// Core sizing macros
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Architectural integer registers, x0 included
`define OOO_ARCH_REGS 32

// Physical registers, p0 is hardwired to zero
`define OOO_PHYS_REGS 64

// Datapath width
`define OOO_XLEN 32

// Index widths for physical and architectural registers
`define OOO_PREG_W 6
`define OOO_AREG_W 5

`endif

//--- hw/ooo_pkg.sv
// Shared core types
`default_nettype none

`include "ooo_defines.svh"

package ooo_pkg;

    // ALU operations supported by the single functional unit
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_e;

    // One instruction as it enters the core in program order
    typedef struct packed {
        alu_op_e                opcode;
        logic [`OOO_AREG_W-1:0] rs1;
        logic [`OOO_AREG_W-1:0] rs2;
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]   imm;
        logic                   use_imm;
    } inst_t;

    // Physical source indices presented to a register file read port
    typedef struct packed {
        logic [`OOO_PREG_W-1:0] rs1_preg;
        logic [`OOO_PREG_W-1:0] rs2_preg;
    } prf_read_t;

    // Operand values and their busy bits after CDB bypass
    typedef struct packed {
        logic [`OOO_XLEN-1:0] rs1_value;
        logic [`OOO_XLEN-1:0] rs2_value;
        logic                 rs1_busy;
        logic                 rs2_busy;
    } prf_resp_t;

    // Operation handed from rename to the ALU
    typedef struct packed {
        alu_op_e                opcode;
        logic [`OOO_XLEN-1:0]   a;
        logic [`OOO_XLEN-1:0]   b;
        logic [`OOO_PREG_W-1:0] dest_preg;
        logic [`OOO_PREG_W-1:0] prev_preg;
        logic [`OOO_AREG_W-1:0] rd;
    } issue_t;

    // Writeback broadcast on the common data bus
    typedef struct packed {
        logic                   valid;
        logic [`OOO_PREG_W-1:0] dest_preg;
        logic [`OOO_PREG_W-1:0] prev_preg;
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]   value;
    } cdb_t;

endpackage

`default_nettype wire

//--- hw/phys_reg_file.sv
// Physical register file with busy bits
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module phys_reg_file
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  cdb_t                   cdb,
    input  logic                   alloc_valid,
    input  logic [`OOO_PREG_W-1:0] alloc_preg,
    input  prf_read_t              dispatch_req,
    output prf_resp_t              dispatch_resp,
    input  logic [`OOO_PREG_W-1:0] arch_preg,
    output logic [`OOO_XLEN-1:0]   arch_value
);

    logic [`OOO_XLEN-1:0]      value_q [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] busy_q;
    logic                      cdb_write;

    // A broadcast to p0 comes from an instruction with rd x0 and stores nothing
    assign cdb_write = cdb.valid && (cdb.dest_preg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                value_q[i] <= '0;
            end
            busy_q <= '0;
        end else begin
            // The result lands and the dependency is resolved at the end of the broadcast
            if (cdb_write) begin
                value_q[cdb.dest_preg] <= cdb.value;
                busy_q[cdb.dest_preg]  <= 1'b0;
            end
            // A fresh destination stays busy until its own broadcast
            if (alloc_valid && (alloc_preg != '0)) begin
                busy_q[alloc_preg] <= 1'b1;
            end
        end
    end

    // Value seen by a read port, forwarding a broadcast in the same cycle
    function automatic logic [`OOO_XLEN-1:0] read_value(input logic [`OOO_PREG_W-1:0] preg);
        logic [`OOO_XLEN-1:0] result;
        if (preg == '0) begin
            result = '0;
        end else if (cdb_write && (cdb.dest_preg == preg)) begin
            result = cdb.value;
        end else begin
            result = value_q[preg];
        end
        return result;
    endfunction

    // Busy bit seen by a read port, cleared early by a matching broadcast
    function automatic logic read_busy(input logic [`OOO_PREG_W-1:0] preg);
        logic result;
        if (preg == '0) begin
            result = 1'b0;
        end else if (cdb_write && (cdb.dest_preg == preg)) begin
            result = 1'b0;
        end else begin
            result = busy_q[preg];
        end
        return result;
    endfunction

    always_comb begin
        // Dispatch port, each operand reads its own index
        dispatch_resp.rs1_value = read_value(dispatch_req.rs1_preg);
        dispatch_resp.rs1_busy  = read_busy(dispatch_req.rs1_preg);
        dispatch_resp.rs2_value = read_value(dispatch_req.rs2_preg);
        dispatch_resp.rs2_busy  = read_busy(dispatch_req.rs2_preg);
        // Architectural inspection port
        arch_value = read_value(arch_preg);
    end

endmodule

`default_nettype wire

//--- hw/rename_unit.sv
// Register renaming and in-order issue
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module rename_unit
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  inst_t                  inst,
    input  cdb_t                   cdb,
    output prf_read_t              dispatch_req,
    input  prf_resp_t              dispatch_resp,
    output logic                   alloc_valid,
    output logic [`OOO_PREG_W-1:0] alloc_preg,
    output logic                   issue_valid,
    output issue_t                 issue,
    input  logic [`OOO_AREG_W-1:0] arch_rs,
    output logic [`OOO_PREG_W-1:0] arch_preg
);

    // At most this many registers are unmapped at any time
    localparam int FREE_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FREE_PTR_W = $clog2(FREE_DEPTH);

    logic [`OOO_PREG_W-1:0] rat_q [`OOO_ARCH_REGS];
    logic [`OOO_PREG_W-1:0] free_q [FREE_DEPTH];
    logic [FREE_PTR_W-1:0]  free_head_q;
    logic [FREE_PTR_W-1:0]  free_tail_q;
    logic [FREE_PTR_W:0]    free_count_q;
    logic                   has_rd;
    logic                   srcs_ready;
    logic                   accept;
    logic                   free_push;
    logic [`OOO_PREG_W-1:0] dest_preg;

    // Sources go through the RAT into the register file's dispatch port
    assign dispatch_req.rs1_preg = rat_q[inst.rs1];
    assign dispatch_req.rs2_preg = rat_q[inst.rs2];
    assign arch_preg             = rat_q[arch_rs];

    assign has_rd = (inst.rd != '0);
    // The second register operand is irrelevant when the immediate replaces it
    assign srcs_ready = !dispatch_resp.rs1_busy && (inst.use_imm || !dispatch_resp.rs2_busy);
    assign inst_ready = srcs_ready && (!has_rd || (free_count_q != '0));
    assign accept     = inst_valid && inst_ready;

    assign alloc_preg  = free_q[free_head_q];
    assign alloc_valid = accept && has_rd;
    // Writes to x0 keep p0 as their destination so nothing gets stored
    assign dest_preg   = has_rd ? alloc_preg : '0;

    // The old mapping retires once its successor broadcasts
    assign free_push = cdb.valid && (cdb.prev_preg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                rat_q[i] <= `OOO_PREG_W'(i);
            end
        end else if (alloc_valid) begin
            rat_q[inst.rd] <= alloc_preg;
        end
    end

    // Circular free list, full out of reset with the upper half of the file
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= `OOO_PREG_W'(`OOO_ARCH_REGS + i);
            end
            free_head_q  <= '0;
            free_tail_q  <= '0;
            free_count_q <= (FREE_PTR_W + 1)'(FREE_DEPTH);
        end else begin
            if (alloc_valid) begin
                free_head_q <= free_head_q + 1'b1;
            end
            if (free_push) begin
                free_q[free_tail_q] <= cdb.prev_preg;
                free_tail_q         <= free_tail_q + 1'b1;
            end
            case ({free_push, alloc_valid})
                2'b10:   free_count_q <= free_count_q + 1'b1;
                2'b01:   free_count_q <= free_count_q - 1'b1;
                default: free_count_q <= free_count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    // Operands are captured at acceptance, forwarded values included
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.opcode    <= inst.opcode;
            issue.a         <= dispatch_resp.rs1_value;
            issue.b         <= inst.use_imm ? inst.imm : dispatch_resp.rs2_value;
            issue.dest_preg <= dest_preg;
            issue.prev_preg <= has_rd ? rat_q[inst.rd] : '0;
            issue.rd        <= inst.rd;
        end
    end

endmodule

`default_nettype wire

//--- hw/alu_pipe.sv
// Two-stage integer ALU
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module alu_pipe
    import ooo_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue_valid,
    input  issue_t issue,
    output cdb_t   cdb
);

    localparam int SHAMT_W = $clog2(`OOO_XLEN);

    issue_t               s1_q;
    logic                 s1_valid_q;
    logic [`OOO_XLEN-1:0] result;

    // Stage one holds the operation and its operands
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_q <= issue;
        end
    end

    always_comb begin
        case (s1_q.opcode)
            alu_add: result = s1_q.a + s1_q.b;
            alu_sub: result = s1_q.a - s1_q.b;
            alu_and: result = s1_q.a & s1_q.b;
            alu_or:  result = s1_q.a | s1_q.b;
            alu_xor: result = s1_q.a ^ s1_q.b;
            // Only the low bits of b count as the shift amount
            alu_sll: result = s1_q.a << s1_q.b[SHAMT_W-1:0];
            alu_srl: result = s1_q.a >> s1_q.b[SHAMT_W-1:0];
            alu_slt: result = `OOO_XLEN'($signed(s1_q.a) < $signed(s1_q.b));
            default: result = '0;
        endcase
    end

    // Stage two drives the bus, the payload only moves with a valid result
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb <= '0;
        end else begin
            cdb.valid <= s1_valid_q;
            if (s1_valid_q) begin
                cdb.dest_preg <= s1_q.dest_preg;
                cdb.prev_preg <= s1_q.prev_preg;
                cdb.rd        <= s1_q.rd;
                cdb.value     <= result;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ooo_core_top.sv
// Rename and writeback core
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    output logic                   inst_ready,
    input  inst_t                  inst,
    output cdb_t                   wb,
    input  logic [`OOO_AREG_W-1:0] arch_rs,
    output logic [`OOO_XLEN-1:0]   arch_value
);

    prf_read_t              dispatch_req;
    prf_resp_t              dispatch_resp;
    logic                   alloc_valid;
    logic [`OOO_PREG_W-1:0] alloc_preg;
    logic [`OOO_PREG_W-1:0] arch_preg;
    logic                   issue_valid;
    issue_t                 issue;

    rename_unit u_rename (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .inst          (inst),
        .cdb           (wb),
        .dispatch_req  (dispatch_req),
        .dispatch_resp (dispatch_resp),
        .alloc_valid   (alloc_valid),
        .alloc_preg    (alloc_preg),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .arch_rs       (arch_rs),
        .arch_preg     (arch_preg)
    );

    phys_reg_file u_prf (
        .clk           (clk),
        .rst           (rst),
        .cdb           (wb),
        .alloc_valid   (alloc_valid),
        .alloc_preg    (alloc_preg),
        .dispatch_req  (dispatch_req),
        .dispatch_resp (dispatch_resp),
        .arch_preg     (arch_preg),
        .arch_value    (arch_value)
    );

    // The ALU output is the CDB and also leaves the core as wb
    alu_pipe u_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (wb)
    );

endmodule

`default_nettype wire

//--- testbench/ooo_core_assertions.sv
// Writeback timing assertions
`timescale 1ns/1ns
`default_nettype none

module ooo_core_assertions
    import ooo_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic inst_valid,
    input logic inst_ready,
    input cdb_t wb
);

    // A stalled instruction waits at most for one producer to reach the CDB
    localparam int STALL_LIMIT = 4;

    logic        accept;
    int unsigned stall_cycles_q;
    // Failed checks, summed into the testbench's closing count
    int unsigned failure_count = 0;

    assign accept = inst_valid && inst_ready;

    // Counts consecutive cycles in which an offered instruction is held back
    always_ff @(posedge clk) begin
        if (rst) begin
            stall_cycles_q <= 0;
        end else if (inst_valid && !inst_ready) begin
            stall_cycles_q <= stall_cycles_q + 1;
        end else begin
            stall_cycles_q <= 0;
        end
    end

    // wb.valid rises at the second edge after the accepting edge
    result_latency: assert property (@(posedge clk) disable iff (rst) accept |-> ##3 wb.valid)
        else begin
            $error("Accepted instruction did not write back two cycles later");
            failure_count++;
        end

    // No broadcast appears without an acceptance at the matching earlier edge
    no_spurious_wb: assert property (@(posedge clk) disable iff (rst) wb.valid |-> $past(accept, 3))
        else begin
            $error("Writeback without a matching acceptance");
            failure_count++;
        end

    // The bus is quiet right after reset
    reset_clears_wb: assert property (@(posedge clk) rst |=> !wb.valid)
        else begin
            $error("Writeback valid after reset");
            failure_count++;
        end

    // A write to x0 carries no physical register at all
    x0_writes_nothing: assert property (@(posedge clk) disable iff (rst)
        (wb.valid && (wb.rd == '0)) |-> ((wb.dest_preg == '0) && (wb.prev_preg == '0)))
        else begin
            $error("Writeback to x0 names a physical register");
            failure_count++;
        end

    // A real destination gets a fresh register and frees a different one
    rd_names_registers: assert property (@(posedge clk) disable iff (rst)
        (wb.valid && (wb.rd != '0)) |->
            ((wb.dest_preg != '0) && (wb.prev_preg != '0) && (wb.dest_preg != wb.prev_preg)))
        else begin
            $error("Writeback to a real register names a bad physical register");
            failure_count++;
        end

    // Once the in-flight results have drained the stall has to end
    stall_bounded: assert property (@(posedge clk) disable iff (rst) stall_cycles_q < STALL_LIMIT)
        else begin
            $error("Instruction input stalled too long");
            failure_count++;
        end

endmodule

bind ooo_core_top ooo_core_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .wb         (wb)
);

`default_nettype wire

//--- testbench/ooo_core_tb.sv
// Rename core testbench
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defines.svh"

module ooo_core_tb
    import ooo_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT  = 50;

    // One expected writeback, queued in acceptance order
    typedef struct packed {
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_XLEN-1:0]   value;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid;
    logic                   inst_ready;
    inst_t                  inst;
    cdb_t                   wb;
    logic [`OOO_AREG_W-1:0] arch_rs;
    logic [`OOO_XLEN-1:0]   arch_value;

    logic [`OOO_XLEN-1:0] model_regs [`OOO_ARCH_REGS];
    expect_t              expected_q [$];
    integer               seed = 32'h35d3_0581;
    int                   check_count;
    int                   error_count;
    int                   test_count;
    int                   errors_at_start;
    string                test_name;

    ooo_core_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .wb         (wb),
        .arch_rs    (arch_rs),
        .arch_value (arch_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Architectural result of one operation, straight from the opcode rules
    function automatic logic [`OOO_XLEN-1:0] reference_alu(input alu_op_e op,
                                                          input logic [`OOO_XLEN-1:0] a,
                                                          input logic [`OOO_XLEN-1:0] b);
        logic [`OOO_XLEN-1:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            alu_slt: r = ($signed(a) < $signed(b)) ? 1 : 0;
            default: r = '0;
        endcase
        return r;
    endfunction

    // Applies an accepted instruction to the model and queues its result
    function automatic void record_accept(input inst_t op);
        logic [`OOO_XLEN-1:0] a;
        logic [`OOO_XLEN-1:0] b;
        expect_t              entry;
        a = model_regs[op.rs1];
        b = op.use_imm ? op.imm : model_regs[op.rs2];
        entry.rd    = op.rd;
        entry.value = reference_alu(op.opcode, a, b);
        expected_q.push_back(entry);
        // x0 stays zero in the model as well
        if (op.rd != '0) begin
            model_regs[op.rd] = entry.value;
        end
    endfunction

    function automatic logic [`OOO_AREG_W-1:0] pick_reg(input int lo, input int span);
        return `OOO_AREG_W'(lo + ($unsigned($random(seed)) % span));
    endfunction

    function automatic inst_t random_inst(input logic [`OOO_AREG_W-1:0] rs1,
                                          input logic [`OOO_AREG_W-1:0] rs2,
                                          input logic [`OOO_AREG_W-1:0] rd);
        inst_t op;
        op.opcode  = alu_op_e'(3'($random(seed)));
        op.rs1     = rs1;
        op.rs2     = rs2;
        op.rd      = rd;
        op.imm     = $random(seed);
        op.use_imm = 1'($random(seed));
        return op;
    endfunction

    // Errors so far, the bound timing assertions included
    function automatic int total_errors();
        return error_count + int'(dut_i.u_assertions.failure_count);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Offers one instruction and returns on the edge that accepts it
    task automatic send(input inst_t op);
        int cycles;
        cycles = 0;
        inst_valid <= 1'b1;
        inst       <= op;
        @(posedge clk);
        while (!inst_ready) begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT) begin
                abort_run($sformatf("Timeout, instruction never accepted in %s", test_name));
            end
            @(posedge clk);
        end
    endtask

    // Stops the stream and waits until every queued result has come back
    task automatic drain();
        int cycles;
        cycles = 0;
        inst_valid <= 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort_run($sformatf("Timeout, results never drained in %s", test_name));
            end
        end while (expected_q.size() != 0);
    endtask

    // Reads architectural registers through the inspection port
    task automatic check_arch(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            arch_rs <= `OOO_AREG_W'(i);
            @(posedge clk);
            check_count++;
            assert (arch_value == model_regs[i]) else begin
                $display("[FAIL] %s: x%0d expected %h, actual %h",
                         test_name, i, model_regs[i], arch_value);
                error_count++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = total_errors();
    endtask

    task automatic end_test();
        test_count++;
        $display("Test %s done with %0d errors", test_name, total_errors() - errors_at_start);
    endtask

    // Acceptance and writeback are both sampled on the rising edge before updates
    always @(posedge clk) begin
        expect_t head;
        if (!rst) begin
            if (wb.valid) begin
                if (expected_q.size() == 0) begin
                    $display("Writeback with no instruction in flight in %s", test_name);
                    error_count++;
                end else begin
                    head = expected_q.pop_front();
                    check_count++;
                    assert ((wb.rd == head.rd) && (wb.value == head.value)) else begin
                        $display("[FAIL] %s: expected rd %0d value %h, actual rd %0d value %h",
                                 test_name, head.rd, head.value, wb.rd, wb.value);
                        error_count++;
                    end
                end
            end
            if (inst_valid && inst_ready) begin
                record_accept(inst);
            end
        end
    end

    initial begin
        logic [`OOO_AREG_W-1:0] rd;
        logic [`OOO_AREG_W-1:0] prev_rd;
        inst_t                  op;
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        arch_rs     = '0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        test_name   = "reset";
        for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Upper registers load from immediates, then lower ones read only upper ones
        begin_test("independent");
        for (int i = 16; i < `OOO_ARCH_REGS; i++) begin
            op         = random_inst('0, '0, `OOO_AREG_W'(i));
            op.use_imm = 1'b1;
            send(op);
        end
        for (int i = 0; i < 40; i++) begin
            send(random_inst(pick_reg(16, 16), pick_reg(16, 16), pick_reg(1, 15)));
        end
        drain();
        end_test();

        // Each instruction consumes the previous result, often through bypass
        begin_test("dependent_chain");
        prev_rd = pick_reg(1, 31);
        for (int i = 0; i < 30; i++) begin
            rd = pick_reg(1, 31);
            send(random_inst(prev_rd, pick_reg(1, 31), rd));
            prev_rd = rd;
        end
        drain();
        end_test();

        begin_test("x0_writes");
        for (int i = 0; i < 12; i++) begin
            send(random_inst(pick_reg(1, 31), pick_reg(0, 32), '0));
        end
        drain();
        check_arch(0, 0);
        end_test();

        begin_test("arch_read");
        check_arch(0, `OOO_ARCH_REGS - 1);
        end_test();

        // Three registers rewritten over and over cycle the free list many times
        begin_test("free_list_recycle");
        for (int i = 0; i < 200; i++) begin
            send(random_inst(pick_reg(1, 3), pick_reg(1, 3), pick_reg(1, 3)));
        end
        drain();
        check_arch(0, `OOO_ARCH_REGS - 1);
        end_test();

        $display("Tests run %0d, checks %0d, errors %0d", test_count, check_count, total_errors());
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ooo_core_top.f
+incdir+hw
hw/ooo_pkg.sv
hw/phys_reg_file.sv
hw/rename_unit.sv
hw/alu_pipe.sv
hw/ooo_core_top.sv
testbench/ooo_core_assertions.sv
testbench/ooo_core_tb.sv
